// File: source/rv_pkg.sv
package rv_pkg;

	// one-hot opcode class positions
	localparam int INST_LUI   = 0;
	localparam int INST_AUIPC = 1;
	localparam int INST_JAL   = 2;
	localparam int INST_JALR  = 3;
	localparam int INST_BEQ   = 4; // all conditional branches
	localparam int INST_LW    = 5;
	localparam int INST_SW    = 6;
	localparam int INST_ADDI  = 7;
	localparam int INST_ADD   = 8;
	localparam int NUM_INST   = 9;

	// alu operators
	localparam logic [3:0] OP_ADD   = 4'd0;
	localparam logic [3:0] OP_SUB   = 4'd1;
	localparam logic [3:0] OP_AND   = 4'd2;
	localparam logic [3:0] OP_XOR   = 4'd3;
	localparam logic [3:0] OP_OR    = 4'd4;
	localparam logic [3:0] OP_SRL   = 4'd5;
	localparam logic [3:0] OP_SRA   = 4'd6;
	localparam logic [3:0] OP_SLL   = 4'd7;
	localparam logic [3:0] OP_LESS  = 4'd8;
	localparam logic [3:0] OP_ULESS = 4'd9;

	// major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_REG    = 7'b0110011;

	// branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	typedef union packed {
		struct packed {logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;} r_fmt;
		struct packed {logic [11:0] imm_11_0; logic [4:0] rs1; logic [2:0] funct3;
			logic [4:0] rd; logic [6:0] opcode;} i_fmt;
		struct packed {logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [4:0] imm_4_0; logic [6:0] opcode;} s_fmt;
		struct packed {logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
			logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;} b_fmt;
		struct packed {logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;} u_fmt;
		struct packed {logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
			logic [4:0] rd; logic [6:0] opcode;} j_fmt;
	} inst_word_t;

endpackage

// File: source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input  rv_pkg::inst_word_t          inst,
	output logic [rv_pkg::NUM_INST-1:0] opcode_type,
	output logic [3:0]                  rd,
	output logic [3:0]                  rs1,
	output logic [3:0]                  rs2,
	output logic [31:0]                 imm,
	output logic [2:0]                  funct3,
	output logic                        funct7_5,
	output logic                        reg_wen
);
	import rv_pkg::*;

	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	// rv32e has 16 registers, top index bit dropped
	assign rd       = inst.r_fmt.rd[3:0];
	assign rs1      = inst.r_fmt.rs1[3:0];
	assign rs2      = inst.r_fmt.rs2[3:0];
	assign funct3   = inst.r_fmt.funct3;
	assign funct7_5 = inst.r_fmt.funct7[5]; // sub / sra select

	always_comb begin
		opcode_type = '0;
		case (inst.r_fmt.opcode)
			OPC_LUI:    opcode_type[INST_LUI]   = 1'b1;
			OPC_AUIPC:  opcode_type[INST_AUIPC] = 1'b1;
			OPC_JAL:    opcode_type[INST_JAL]   = 1'b1;
			OPC_JALR:   opcode_type[INST_JALR]  = 1'b1;
			OPC_BRANCH: opcode_type[INST_BEQ]   = 1'b1;
			OPC_LOAD:   opcode_type[INST_LW]    = 1'b1;
			OPC_STORE:  opcode_type[INST_SW]    = 1'b1;
			OPC_IMM:    opcode_type[INST_ADDI]  = 1'b1;
			OPC_REG:    opcode_type[INST_ADD]   = 1'b1;
			default:    opcode_type = '0; // unknown acts as nop
		endcase
	end

	// immediates per format, all sign extended
	assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
	assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
	assign imm_b = {
		{19{inst.b_fmt.imm_12}},
		inst.b_fmt.imm_12,
		inst.b_fmt.imm_11,
		inst.b_fmt.imm_10_5,
		inst.b_fmt.imm_4_1,
		1'b0
	};
	assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
	assign imm_j = {
		{11{inst.j_fmt.imm_20}},
		inst.j_fmt.imm_20,
		inst.j_fmt.imm_19_12,
		inst.j_fmt.imm_11,
		inst.j_fmt.imm_10_1,
		1'b0
	};

	always_comb begin
		case (1'b1)
			opcode_type[INST_LUI], opcode_type[INST_AUIPC]: imm = imm_u;
			opcode_type[INST_JAL]:                          imm = imm_j;
			opcode_type[INST_BEQ]:                          imm = imm_b;
			opcode_type[INST_SW]:                           imm = imm_s;
			opcode_type[INST_JALR], opcode_type[INST_LW], opcode_type[INST_ADDI]: begin
				imm = imm_i;
			end
			default: imm = '0; // r-type has no immediate
		endcase
	end

	// loads write back outside this slice
	assign reg_wen = (|opcode_type)
		& ~(opcode_type[INST_BEQ] | opcode_type[INST_LW] | opcode_type[INST_SW]);

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic        clock,
	input  logic        reset,
	input  logic [3:0]  rs1,
	input  logic [3:0]  rs2,
	output logic [31:0] src1,
	output logic [31:0] src2,
	input  logic        wen,
	input  logic [3:0]  waddr,
	input  logic [31:0] wdata
);

	logic [31:0] regs [1:15]; // x0 not stored

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != 4'd0)) begin
			regs[waddr] <= wdata;
		end
	end

	// combinational reads, x0 reads zero
	assign src1 = (rs1 == 4'd0) ? 32'd0 : regs[rs1];
	assign src2 = (rs2 == 4'd0) ? 32'd0 : regs[rs2];

endmodule

// File: source/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
	input  logic                        clock,
	input  logic                        reset,
	input  logic [rv_pkg::NUM_INST-1:0] opcode_type,
	input  logic [3:0]                  rd,
	input  logic [31:0]                 src1,
	input  logic [31:0]                 src2,
	input  logic [31:0]                 imm,
	input  logic [2:0]                  funct3,
	input  logic                        funct7_5,
	input  logic [31:0]                 pc,
	input  logic [31:0]                 dnpc,
	input  logic                        reg_wen,
	input  logic                        exu_valid,
	input  logic                        exu_ready,
	output logic [3:0]                  rd_next,
	output logic [31:0]                 pc_next,
	output logic                        reg_wen_next,
	output logic [31:0]                 jump_addr,
	output logic                        jump_wrong,
	output logic                        btb_wvalid,
	output logic [31:0]                 val,
	output logic                        lsu_ren,
	output logic                        lsu_wen
);
	import rv_pkg::*;

	logic        fire;
	logic [31:0] loperand;
	logic [31:0] roperand;
	logic [3:0]  operator;
	logic [31:0] op_sum;
	logic [31:0] op_diff;
	logic        op_borrow;
	logic        op_less;
	logic [31:0] alu_val;
	logic [31:0] cmp_diff;
	logic        cmp_borrow;
	logic        cmp_less;
	logic        jump_cond;
	logic        jump_en;
	logic        jal_enable;
	logic [31:0] snpc;
	logic [31:0] jump_addr_tmp;
	logic        mispredict;
	logic        need_btb;

	assign fire       = exu_valid & exu_ready;
	assign snpc       = pc + 32'd4;
	assign jal_enable = opcode_type[INST_JAL] | opcode_type[INST_JALR];
	assign lsu_ren    = opcode_type[INST_LW];
	assign lsu_wen    = opcode_type[INST_SW];

	assign loperand = (opcode_type[INST_AUIPC] | opcode_type[INST_JAL] | opcode_type[INST_BEQ])
		? pc : opcode_type[INST_LUI] ? 32'd0 : src1;
	assign roperand = opcode_type[INST_ADD] ? src2 : imm;

	always_comb begin
		operator = OP_ADD; // address arithmetic by default
		if (opcode_type[INST_ADDI] | opcode_type[INST_ADD]) begin
			case (funct3)
				3'b000: operator = (opcode_type[INST_ADD] & funct7_5) ? OP_SUB : OP_ADD;
				3'b001: operator = OP_SLL;
				3'b010: operator = OP_LESS;
				3'b011: operator = OP_ULESS;
				3'b100: operator = OP_XOR;
				3'b101: operator = funct7_5 ? OP_SRA : OP_SRL;
				3'b110: operator = OP_OR;
				default: operator = OP_AND;
			endcase
		end
	end

	assign op_sum = loperand + roperand;
	assign {op_borrow, op_diff} = {1'b0, loperand} - {1'b0, roperand};
	// signs differ: left negative means less, else the difference sign decides
	assign op_less = (loperand[31] & ~roperand[31])
		| (~(loperand[31] ^ roperand[31]) & op_diff[31]);

	always_comb begin
		case (operator)
			OP_SUB:   alu_val = op_diff;
			OP_AND:   alu_val = loperand & roperand;
			OP_XOR:   alu_val = loperand ^ roperand;
			OP_OR:    alu_val = loperand | roperand;
			OP_SRL:   alu_val = loperand >> roperand[4:0];
			OP_SRA:   alu_val = $signed(loperand) >>> roperand[4:0];
			OP_SLL:   alu_val = loperand << roperand[4:0];
			OP_LESS:  alu_val = {31'd0, op_less};
			OP_ULESS: alu_val = {31'd0, op_borrow};
			default:  alu_val = op_sum;
		endcase
	end

	// branch compare always on the registers
	assign {cmp_borrow, cmp_diff} = {1'b0, src1} - {1'b0, src2};
	assign cmp_less = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & cmp_diff[31]);

	always_comb begin
		case (funct3)
			F3_BEQ:  jump_cond = ~|cmp_diff;
			F3_BNE:  jump_cond = |cmp_diff;
			F3_BLT:  jump_cond = cmp_less;
			F3_BGE:  jump_cond = ~cmp_less;
			F3_BLTU: jump_cond = cmp_borrow;
			F3_BGEU: jump_cond = ~cmp_borrow;
			default: jump_cond = 1'b0;
		endcase
	end

	assign jump_en       = jal_enable | (opcode_type[INST_BEQ] & jump_cond);
	assign jump_addr_tmp = jump_en ? op_sum : snpc;
	assign val           = jal_enable ? snpc : alu_val; // link address for jal/jalr
	assign mispredict    = jump_addr_tmp != dnpc;
	assign need_btb      = (opcode_type[INST_BEQ] & imm[31]) | opcode_type[INST_JAL];

	always_ff @(posedge clock) begin
		if (reset) begin
			jump_wrong   <= 1'b0;
			btb_wvalid   <= 1'b0;
			reg_wen_next <= 1'b0;
		end else if (fire) begin
			jump_wrong   <= mispredict;
			btb_wvalid   <= mispredict & need_btb;
			reg_wen_next <= reg_wen;
		end else begin
			jump_wrong <= 1'b0; // redirect is a one cycle pulse
			btb_wvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fire) begin
			rd_next   <= rd;
			pc_next   <= pc;
			jump_addr <= jump_addr_tmp;
		end
	end

endmodule

// File: source/exec_core.sv
`timescale 1ns/1ps

module exec_core (
	input  logic               clock,
	input  logic               reset,
	input  rv_pkg::inst_word_t inst,
	input  logic [31:0]        pc,
	input  logic [31:0]        dnpc,
	input  logic               inst_valid,
	input  logic               inst_ready,
	output logic [31:0]        val,
	output logic [3:0]         rd_next,
	output logic [31:0]        pc_next,
	output logic               reg_wen_next,
	output logic [31:0]        jump_addr,
	output logic               jump_wrong,
	output logic               btb_wvalid,
	output logic               lsu_ren,
	output logic               lsu_wen,
	output logic [31:0]        store_data
);
	import rv_pkg::*;

	logic [NUM_INST-1:0] opcode_type;
	logic [3:0]          rd;
	logic [3:0]          rs1;
	logic [3:0]          rs2;
	logic [31:0]         imm;
	logic [2:0]          funct3;
	logic                funct7_5;
	logic                reg_wen;
	logic [31:0]         src1;

	inst_decoder u_decoder (
		.inst        (inst),
		.opcode_type (opcode_type),
		.rd          (rd),
		.rs1         (rs1),
		.rs2         (rs2),
		.imm         (imm),
		.funct3      (funct3),
		.funct7_5    (funct7_5),
		.reg_wen     (reg_wen)
	);

	// write on the accepting edge only
	reg_file u_reg_file (
		.clock (clock),
		.reset (reset),
		.rs1   (rs1),
		.rs2   (rs2),
		.src1  (src1),
		.src2  (store_data), // rs2 value doubles as store data
		.wen   (reg_wen & inst_valid & inst_ready),
		.waddr (rd),
		.wdata (val)
	);

	exec_unit u_exec_unit (
		.clock        (clock),
		.reset        (reset),
		.opcode_type  (opcode_type),
		.rd           (rd),
		.src1         (src1),
		.src2         (store_data),
		.imm          (imm),
		.funct3       (funct3),
		.funct7_5     (funct7_5),
		.pc           (pc),
		.dnpc         (dnpc),
		.reg_wen      (reg_wen),
		.exu_valid    (inst_valid),
		.exu_ready    (inst_ready),
		.rd_next      (rd_next),
		.pc_next      (pc_next),
		.reg_wen_next (reg_wen_next),
		.jump_addr    (jump_addr),
		.jump_wrong   (jump_wrong),
		.btb_wvalid   (btb_wvalid),
		.val          (val),
		.lsu_ren      (lsu_ren),
		.lsu_wen      (lsu_wen)
	);

endmodule

// File: verif/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb;
	import rv_pkg::*;

	localparam int ACCEPT_TIMEOUT = 64;
	localparam int NUM_RANDOM     = 400;

	logic        clock;
	logic        reset;
	inst_word_t  inst;
	logic [31:0] pc, dnpc;
	logic        inst_valid, inst_ready;
	logic [31:0] val, pc_next, jump_addr, store_data;
	logic [3:0]  rd_next;
	logic        reg_wen_next, jump_wrong, btb_wvalid, lsu_ren, lsu_wen;

	logic [31:0] seed;
	logic [31:0] model_regs [16];
	string       cur_test;
	int          checks, errors, tests;

	// instruction being issued and its expected results
	int          e_cls;
	logic [31:0] e_word, e_pc, e_dnpc, e_val, e_target, e_store;
	logic [3:0]  e_rd;
	logic        e_wen, e_btb_cand;
	logic        p_fire, p_wrong, p_btb; // redirect due one cycle after accept
	logic        p_wen;
	logic [3:0]  p_rd;
	logic [31:0] p_target, p_pc;

	exec_core dut0 (.*);

	always #2 clock = ~clock;

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed ^ (seed >> 16);
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// rv32 integer op semantics
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] x, input logic [31:0] y, input logic is_reg);
		case (f3)
			3'b000: return (is_reg && alt) ? x - y : x + y;
			3'b001: return x << y[4:0];
			3'b010: return {31'd0, $signed(x) < $signed(y)};
			3'b011: return {31'd0, x < y};
			3'b100: return x ^ y;
			3'b101: begin
				if (alt) return $signed(x) >>> y[4:0];
				return x >> y[4:0];
			end
			3'b110: return x | y;
			default: return x & y;
		endcase
	endfunction

	task automatic compare(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
		end
	endtask

	// encode one instruction with expected values from the register model
	task automatic build_inst(input int cls, input logic [3:0] rd, input logic [3:0] rs1,
		input logic [3:0] rs2, input logic [2:0] f3, input logic alt, input logic [31:0] imm);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] snpc;
		logic [11:0] i12;
		logic [6:0]  f7;
		logic        taken;
		a = model_regs[rs1];
		b = model_regs[rs2];
		i12 = imm[11:0];
		e_cls = cls;
		e_pc = next_rand() & 32'hffff_fffc;
		snpc = e_pc + 32'd4;
		f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
		e_rd = rd;
		e_val = snpc; // link value for jal/jalr
		e_target = snpc;
		e_store = b;
		e_wen = !(cls == INST_BEQ || cls == INST_LW || cls == INST_SW);
		e_btb_cand = (cls == INST_JAL);
		case (cls)
			INST_LUI: begin
				e_word = {imm[31:12], 1'b0, rd, OPC_LUI};
				e_val = {imm[31:12], 12'd0};
			end
			INST_AUIPC: begin
				e_word = {imm[31:12], 1'b0, rd, OPC_AUIPC};
				e_val = e_pc + {imm[31:12], 12'd0};
			end
			INST_JAL: begin
				e_word = {imm[20], imm[10:1], imm[11], imm[19:12], 1'b0, rd, OPC_JAL};
				e_target = e_pc + {{11{imm[20]}}, imm[20:1], 1'b0};
			end
			INST_JALR: begin
				e_word = {i12, 1'b0, rs1, 3'b000, 1'b0, rd, OPC_JALR};
				e_target = a + sext12(i12);
			end
			INST_BEQ: begin
				e_word = {imm[12], imm[10:5], 1'b0, rs2, 1'b0, rs1, f3, imm[4:1], imm[11],
					OPC_BRANCH};
				case (f3)
					F3_BEQ:  taken = a == b;
					F3_BNE:  taken = a != b;
					F3_BLT:  taken = $signed(a) < $signed(b);
					F3_BGE:  taken = $signed(a) >= $signed(b);
					F3_BLTU: taken = a < b;
					default: taken = a >= b;
				endcase
				if (taken) e_target = e_pc + {{19{imm[12]}}, imm[12:1], 1'b0};
				e_btb_cand = imm[12]; // backward branch
			end
			INST_LW: begin
				e_word = {i12, 1'b0, rs1, 3'b010, 1'b0, rd, OPC_LOAD};
				e_val = a + sext12(i12);
			end
			INST_SW: begin
				e_word = {i12[11:5], 1'b0, rs2, 1'b0, rs1, 3'b010, i12[4:0], OPC_STORE};
				e_val = a + sext12(i12);
			end
			INST_ADDI: begin
				if (f3 == 3'b001 || f3 == 3'b101) i12[11:5] = f7; // shamt form
				e_word = {i12, 1'b0, rs1, f3, 1'b0, rd, OPC_IMM};
				e_val = alu_model(f3, f7[5], a, sext12(i12), 1'b0);
			end
			default: begin
				e_word = {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, OPC_REG};
				e_val = alu_model(f3, f7[5], a, b, 1'b1);
			end
		endcase
		e_dnpc = ((next_rand() & 32'h100) != 0) ? e_target : (next_rand() & 32'hffff_fffc);
	endtask

	task automatic random_inst();
		int          cls;
		logic [31:0] f;
		logic [2:0]  f3;
		cls = int'(next_rand() % 32'd9);
		f = next_rand();
		f3 = f[14:12];
		// 010 and 011 are no branches
		if (cls == INST_BEQ && f3[2:1] == 2'b01) f3[2] = 1'b1;
		build_inst(cls, f[3:0], f[7:4], f[11:8], f3, f[15], next_rand());
	endtask

	task automatic check_redirect();
		if (p_fire) begin
			compare("jump_addr", p_target, jump_addr);
			compare("jump_wrong", 32'(p_wrong), 32'(jump_wrong));
			compare("btb_wvalid", 32'(p_btb), 32'(btb_wvalid));
			compare("rd_next", 32'(p_rd), 32'(rd_next));
			compare("pc_next", p_pc, pc_next);
			compare("reg_wen_next", 32'(p_wen), 32'(reg_wen_next));
		end else begin
			compare("idle jump_wrong", 32'd0, 32'(jump_wrong));
			compare("idle btb_wvalid", 32'd0, 32'(btb_wvalid));
		end
	endtask

	// hold the word with a random handshake until it is taken
	task automatic issue_inst();
		int          n;
		logic        fired;
		logic [31:0] r;
		fired = 1'b0;
		n = 0;
		while (!fired && n < ACCEPT_TIMEOUT) begin
			r = next_rand();
			@(posedge clock);
			inst <= e_word;
			pc <= e_pc;
			dnpc <= e_dnpc;
			inst_valid <= r[9];
			inst_ready <= r[22];
			@(negedge clock);
			check_redirect();
			fired = inst_valid & inst_ready;
			p_fire = fired;
			n++;
		end
		if (!fired) begin
			$display("timeout: instruction %h not accepted within %0d cycles",
				e_word, ACCEPT_TIMEOUT);
			$display("=== FAIL ===");
			$finish;
		end else begin
			if (e_cls != INST_BEQ) compare("val", e_val, val);
			compare("lsu_ren", 32'(e_cls == INST_LW), 32'(lsu_ren));
			compare("lsu_wen", 32'(e_cls == INST_SW), 32'(lsu_wen));
			if (e_cls == INST_SW) compare("store_data", e_store, store_data);
			if (e_wen && e_rd != 4'd0) model_regs[e_rd] = e_val;
			p_target = e_target;
			p_wrong = e_target != e_dnpc;
			p_btb = p_wrong & e_btb_cand;
			p_pc = e_pc;
			p_rd = e_word[10:7]; // low bits of the rd field
			p_wen = e_wen;
		end
	endtask

	task automatic idle_cycle();
		@(posedge clock);
		inst_valid <= 1'b0;
		@(negedge clock);
		check_redirect();
		p_fire = 1'b0;
	endtask

	// add x0, xi, x0 puts each register on val
	task automatic read_back_all();
		for (int i = 0; i < 16; i++) begin
			build_inst(INST_ADD, 4'd0, 4'(i), 4'd0, 3'b000, 1'b0, 32'd0);
			issue_inst();
		end
		idle_cycle();
	endtask

	task automatic finish_test(input int errors_before);
		tests++;
		$display("test %s finished with %0d errors", cur_test, errors - errors_before);
	endtask

	initial begin
		int err0;
		clock = 1'b0;
		reset = 1'b1;
		inst = '0;
		pc = 32'd0;
		dnpc = 32'd0;
		inst_valid = 1'b0;
		inst_ready = 1'b0;
		seed = 32'h9360d396;
		checks = 0;
		errors = 0;
		tests = 0;
		p_fire = 1'b0;
		for (int i = 0; i < 16; i++) model_regs[i] = 32'd0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;

		cur_test = "reset";
		err0 = errors;
		@(negedge clock);
		compare("jump_wrong", 32'd0, 32'(jump_wrong));
		compare("btb_wvalid", 32'd0, 32'(btb_wvalid));
		compare("reg_wen_next", 32'd0, 32'(reg_wen_next));
		read_back_all();
		finish_test(err0);

		cur_test = "random_ops";
		err0 = errors;
		repeat (NUM_RANDOM) begin
			random_inst();
			issue_inst();
		end
		idle_cycle();
		finish_test(err0);

		cur_test = "readback";
		err0 = errors;
		read_back_all();
		finish_test(err0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: verilog.f
source/rv_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/exec_core.sv
verif/exec_core_tb.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then scan the log for the result
rm -rf obj_dir sim.log
verilator --binary --timing -f verilog.f --top-module exec_core_tb -o exec_core_sim \
	&& ./obj_dir/exec_core_sim > sim.log 2>&1 \
	|| { echo "build or run failed"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0
